// File: source/rom_loader_pkg.sv
// ############################
// Widths, SDRAM memory map and protocol encodings
// Base addresses assume the cartridge layout of the console core
// ############################
`default_nettype none

package rom_loader_pkg;

    localparam int BYTE_W       = 8;
    localparam int OFFSET_W     = 24;
    localparam int SDRAM_ADDR_W = 25;

    // Start of each ROM region in SDRAM
    localparam logic [SDRAM_ADDR_W-1:0] BASE_BIOS = 25'h0000000;
    localparam logic [SDRAM_ADDR_W-1:0] BASE_P    = 25'h0020000;
    localparam logic [SDRAM_ADDR_W-1:0] BASE_C    = 25'h0100000;
    localparam logic [SDRAM_ADDR_W-1:0] BASE_V    = 25'h0200000;
    localparam logic [SDRAM_ADDR_W-1:0] BASE_M    = 25'h0280000;
    localparam logic [SDRAM_ADDR_W-1:0] BASE_S    = 25'h0300000;

    // Region boundaries inside a single .NEO image
    localparam logic [OFFSET_W-1:0] NEO_C_START = 24'h100000;
    localparam logic [OFFSET_W-1:0] NEO_V_START = 24'h200000;
    localparam logic [OFFSET_W-1:0] NEO_M_START = 24'h300000;
    localparam logic [OFFSET_W-1:0] NEO_S_START = 24'h380000;

    typedef enum logic [7:0] {
        LOAD_START = 8'h01,
        LOAD_DATA  = 8'h02,
        LOAD_END   = 8'h03,
        LOAD_ABORT = 8'h04
    } loader_cmd_e;

    // Value 7 is left unnamed and maps to base 0
    typedef enum logic [2:0] {
        BIOS = 3'd0,
        P    = 3'd1,
        S    = 3'd2,
        M    = 3'd3,
        V    = 3'd4,
        C    = 3'd5,
        NEO  = 3'd6
    } rom_type_e;

    typedef enum logic [2:0] {
        FIELD_TYPE,
        FIELD_OFF_H,
        FIELD_OFF_M,
        FIELD_OFF_L,
        FIELD_SIZE_H,
        FIELD_SIZE_M,
        FIELD_SIZE_L
    } header_field_e;

    // Header states are consecutive and end just before S_CMD
    typedef enum logic [3:0] {
        S_IDLE,
        S_TYPE,
        S_OFF_H,
        S_OFF_M,
        S_OFF_L,
        S_SIZE_H,
        S_SIZE_M,
        S_SIZE_L,
        S_CMD,
        S_DATA,
        S_TAIL,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

// File: source/loader_ctrl_if.sv
// ############################
// Control strobes between sequencer and datapath
// ############################
`timescale 1ns/1ps
`default_nettype none

interface loader_ctrl_if;

    // Header capture strobe and target field
    logic                          field_we;
    rom_loader_pkg::header_field_e field_sel;

    // Write stream control
    logic start_load;
    logic data_we;

    // Status back to the sequencer
    logic size_zero;
    logic last_byte;

    modport seq (
        output field_we,
        output field_sel,
        output start_load,
        output data_we,
        input  size_zero,
        input  last_byte
    );

    modport capture (
        input  field_we,
        input  field_sel,
        output size_zero
    );

    modport stream (
        input  start_load,
        input  data_we,
        output last_byte
    );

endinterface

`default_nettype wire

// File: source/load_sequencer.sv
// ############################
// Data bytes are counted by size, never decoded
// ############################
`timescale 1ns/1ps
`default_nettype none

module load_sequencer (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic [rom_loader_pkg::BYTE_W-1:0] uart_data,
    input  wire logic                              uart_valid,
    output logic                                   uart_ready,
    output logic                                   rom_busy,
    output logic                                   rom_done,
    loader_ctrl_if.seq                             ctrl
);

    rom_loader_pkg::seq_state_e  state;
    rom_loader_pkg::seq_state_e  next_state;
    rom_loader_pkg::loader_cmd_e cmd;
    logic                        accept;

    assign accept = uart_valid && uart_ready;
    assign cmd    = rom_loader_pkg::loader_cmd_e'(uart_data);

    always_comb begin
        next_state      = state;
        ctrl.field_we   = 1'b0;
        ctrl.start_load = 1'b0;
        ctrl.data_we    = 1'b0;
        case (state)
            rom_loader_pkg::S_IDLE: begin
                if (accept && cmd == rom_loader_pkg::LOAD_START) begin
                    next_state = rom_loader_pkg::S_TYPE;
                end
            end
            rom_loader_pkg::S_TYPE,
            rom_loader_pkg::S_OFF_H,
            rom_loader_pkg::S_OFF_M,
            rom_loader_pkg::S_OFF_L,
            rom_loader_pkg::S_SIZE_H,
            rom_loader_pkg::S_SIZE_M,
            rom_loader_pkg::S_SIZE_L: begin
                // One header byte per state, S_SIZE_L falls through to S_CMD
                ctrl.field_we = accept;
                if (accept) begin
                    next_state = rom_loader_pkg::seq_state_e'(state + 4'd1);
                end
            end
            rom_loader_pkg::S_CMD: begin
                if (accept) begin
                    case (cmd)
                        rom_loader_pkg::LOAD_DATA: begin
                            ctrl.start_load = 1'b1;
                            next_state = ctrl.size_zero ? rom_loader_pkg::S_TAIL
                                                        : rom_loader_pkg::S_DATA;
                        end
                        rom_loader_pkg::LOAD_END:   next_state = rom_loader_pkg::S_DONE;
                        rom_loader_pkg::LOAD_ABORT: next_state = rom_loader_pkg::S_IDLE;
                        default:                    next_state = state;
                    endcase
                end
            end
            rom_loader_pkg::S_DATA: begin
                ctrl.data_we = accept;
                if (accept && ctrl.last_byte) begin
                    next_state = rom_loader_pkg::S_TAIL;
                end
            end
            rom_loader_pkg::S_TAIL: begin
                if (accept && cmd == rom_loader_pkg::LOAD_END) begin
                    next_state = rom_loader_pkg::S_DONE;
                end else if (accept && cmd == rom_loader_pkg::LOAD_ABORT) begin
                    next_state = rom_loader_pkg::S_IDLE;
                end
            end
            rom_loader_pkg::S_DONE: next_state = rom_loader_pkg::S_IDLE;
            default:                next_state = rom_loader_pkg::S_IDLE;
        endcase
    end

    // Header byte to field mapping
    always_comb begin
        case (state)
            rom_loader_pkg::S_OFF_H:  ctrl.field_sel = rom_loader_pkg::FIELD_OFF_H;
            rom_loader_pkg::S_OFF_M:  ctrl.field_sel = rom_loader_pkg::FIELD_OFF_M;
            rom_loader_pkg::S_OFF_L:  ctrl.field_sel = rom_loader_pkg::FIELD_OFF_L;
            rom_loader_pkg::S_SIZE_H: ctrl.field_sel = rom_loader_pkg::FIELD_SIZE_H;
            rom_loader_pkg::S_SIZE_M: ctrl.field_sel = rom_loader_pkg::FIELD_SIZE_M;
            rom_loader_pkg::S_SIZE_L: ctrl.field_sel = rom_loader_pkg::FIELD_SIZE_L;
            default:                  ctrl.field_sel = rom_loader_pkg::FIELD_TYPE;
        endcase
    end

    // Status outputs follow the state being entered
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= rom_loader_pkg::S_IDLE;
            uart_ready <= 1'b0;
            rom_busy   <= 1'b0;
            rom_done   <= 1'b0;
        end else begin
            state      <= next_state;
            // Ready drops for the single done cycle only
            uart_ready <= (next_state != rom_loader_pkg::S_DONE);
            rom_busy   <= (next_state != rom_loader_pkg::S_IDLE) &&
                          (next_state != rom_loader_pkg::S_DONE);
            // S_DONE is reached only through LOAD_END
            rom_done   <= (next_state == rom_loader_pkg::S_DONE);
        end
    end

endmodule

`default_nettype wire

// File: source/header_capture.sv
// ############################
// Offset and size arrive big-endian
// ############################
`timescale 1ns/1ps
`default_nettype none

module header_capture (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic [rom_loader_pkg::BYTE_W-1:0]   uart_data,
    loader_ctrl_if.capture                           ctrl,
    output rom_loader_pkg::rom_type_e                rom_type,
    output logic [rom_loader_pkg::OFFSET_W-1:0]      rom_offset,
    output logic [rom_loader_pkg::OFFSET_W-1:0]      rom_size
);

    always_ff @(posedge clk) begin
        if (reset) begin
            rom_type   <= rom_loader_pkg::BIOS;
            rom_offset <= '0;
            rom_size   <= '0;
        end else if (ctrl.field_we) begin
            case (ctrl.field_sel)
                // Only the low three bits of the type byte are meaningful
                rom_loader_pkg::FIELD_TYPE:
                    rom_type <= rom_loader_pkg::rom_type_e'(uart_data[2:0]);
                rom_loader_pkg::FIELD_OFF_H:  rom_offset[23:16] <= uart_data;
                rom_loader_pkg::FIELD_OFF_M:  rom_offset[15:8]  <= uart_data;
                rom_loader_pkg::FIELD_OFF_L:  rom_offset[7:0]   <= uart_data;
                rom_loader_pkg::FIELD_SIZE_H: rom_size[23:16]   <= uart_data;
                rom_loader_pkg::FIELD_SIZE_M: rom_size[15:8]    <= uart_data;
                rom_loader_pkg::FIELD_SIZE_L: rom_size[7:0]     <= uart_data;
                default:                      rom_size          <= rom_size;
            endcase
        end
    end

    // Lets LOAD_DATA skip straight to the tail
    assign ctrl.size_zero = (rom_size == '0);

endmodule

`default_nettype wire

// File: source/region_mapper.sv
// ############################
// Pure logic; inputs must be stable before LOAD_DATA
// ############################
`timescale 1ns/1ps
`default_nettype none

module region_mapper (
    input  wire rom_loader_pkg::rom_type_e              rom_type,
    input  wire logic [rom_loader_pkg::OFFSET_W-1:0]    rom_offset,
    output logic [rom_loader_pkg::SDRAM_ADDR_W-1:0]     start_addr
);

    logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] base;
    logic [rom_loader_pkg::OFFSET_W-1:0]     rel_off;

    always_comb begin
        base    = '0;
        rel_off = rom_offset;
        case (rom_type)
            rom_loader_pkg::BIOS: base = rom_loader_pkg::BASE_BIOS;
            rom_loader_pkg::P:    base = rom_loader_pkg::BASE_P;
            rom_loader_pkg::S:    base = rom_loader_pkg::BASE_S;
            rom_loader_pkg::M:    base = rom_loader_pkg::BASE_M;
            rom_loader_pkg::V:    base = rom_loader_pkg::BASE_V;
            rom_loader_pkg::C:    base = rom_loader_pkg::BASE_C;
            rom_loader_pkg::NEO: begin
                // Single file image where the offset picks the region
                if (rom_offset < rom_loader_pkg::NEO_C_START) begin
                    base = rom_loader_pkg::BASE_P;
                end else if (rom_offset < rom_loader_pkg::NEO_V_START) begin
                    base    = rom_loader_pkg::BASE_C;
                    rel_off = rom_offset - rom_loader_pkg::NEO_C_START;
                end else if (rom_offset < rom_loader_pkg::NEO_M_START) begin
                    base    = rom_loader_pkg::BASE_V;
                    rel_off = rom_offset - rom_loader_pkg::NEO_V_START;
                end else if (rom_offset < rom_loader_pkg::NEO_S_START) begin
                    base    = rom_loader_pkg::BASE_M;
                    rel_off = rom_offset - rom_loader_pkg::NEO_M_START;
                end else begin
                    base    = rom_loader_pkg::BASE_S;
                    rel_off = rom_offset - rom_loader_pkg::NEO_S_START;
                end
            end
            // Unnamed type 7 writes at the raw offset
            default: base = '0;
        endcase
    end

    assign start_addr = base + (rom_loader_pkg::SDRAM_ADDR_W)'(rel_off);

endmodule

`default_nettype wire

// File: source/sdram_write_stream.sv
// ############################
// One write per data byte with no stall from SDRAM
// ############################
`timescale 1ns/1ps
`default_nettype none

module sdram_write_stream (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire logic [rom_loader_pkg::BYTE_W-1:0]       uart_data,
    input  wire logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] start_addr,
    input  wire logic [rom_loader_pkg::OFFSET_W-1:0]     rom_size,
    loader_ctrl_if.stream                                ctrl,
    output logic [rom_loader_pkg::SDRAM_ADDR_W-1:0]      sdram_addr,
    output logic [rom_loader_pkg::BYTE_W-1:0]            sdram_data,
    output logic                                         sdram_wr
);

    logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] addr_cnt;
    logic [rom_loader_pkg::OFFSET_W-1:0]     remaining;

    // Write strobe and bytes left in the current load
    always_ff @(posedge clk) begin
        if (reset) begin
            sdram_wr  <= 1'b0;
            remaining <= '0;
        end else begin
            sdram_wr <= ctrl.data_we;
            if (ctrl.start_load) begin
                remaining <= rom_size;
            end else if (ctrl.data_we) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // Address counter and write payload
    always_ff @(posedge clk) begin
        if (ctrl.start_load) begin
            addr_cnt <= start_addr;
        end else if (ctrl.data_we) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
        if (ctrl.data_we) begin
            sdram_addr <= addr_cnt;
            sdram_data <= uart_data;
        end
    end

    // High while the final byte of the load is still expected
    assign ctrl.last_byte = (remaining == (rom_loader_pkg::OFFSET_W)'(1));

endmodule

`default_nettype wire

// File: source/rom_loader.sv
// ############################
// No SDRAM back-pressure; each write is one cycle
// Source must hold uart_data while uart_ready is low
// ############################
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
    input  wire logic                                    clk,
    input  wire logic                                    reset,

    // Byte port from the microcontroller
    input  wire logic [rom_loader_pkg::BYTE_W-1:0]       uart_data,
    input  wire logic                                    uart_valid,
    output logic                                         uart_ready,

    // Load status
    output logic                                         rom_busy,
    output logic                                         rom_done,

    // SDRAM write port
    output logic [rom_loader_pkg::SDRAM_ADDR_W-1:0]      sdram_addr,
    output logic [rom_loader_pkg::BYTE_W-1:0]            sdram_data,
    output logic                                         sdram_wr
);

    rom_loader_pkg::rom_type_e               rom_type;
    logic [rom_loader_pkg::OFFSET_W-1:0]     rom_offset;
    logic [rom_loader_pkg::OFFSET_W-1:0]     rom_size;
    logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] start_addr;

    loader_ctrl_if ctrl ();

    load_sequencer i_sequencer (
        .clk        (clk),
        .reset      (reset),
        .uart_data  (uart_data),
        .uart_valid (uart_valid),
        .uart_ready (uart_ready),
        .rom_busy   (rom_busy),
        .rom_done   (rom_done),
        .ctrl       (ctrl.seq)
    );

    header_capture i_header (
        .clk        (clk),
        .reset      (reset),
        .uart_data  (uart_data),
        .ctrl       (ctrl.capture),
        .rom_type   (rom_type),
        .rom_offset (rom_offset),
        .rom_size   (rom_size)
    );

    region_mapper i_mapper (
        .rom_type   (rom_type),
        .rom_offset (rom_offset),
        .start_addr (start_addr)
    );

    sdram_write_stream i_stream (
        .clk        (clk),
        .reset      (reset),
        .uart_data  (uart_data),
        .start_addr (start_addr),
        .rom_size   (rom_size),
        .ctrl       (ctrl.stream),
        .sdram_addr (sdram_addr),
        .sdram_data (sdram_data),
        .sdram_wr   (sdram_wr)
    );

endmodule

`default_nettype wire

// File: dv/tb_rom_loader.sv
// ##############################
// Inputs change on the falling edge and outputs are checked on the falling edge
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_rom_loader;

    typedef enum logic [2:0] {K_PLAIN, K_DATA, K_START, K_END, K_ABORT} byte_kind_e;
    typedef enum logic [1:0] {E_END, E_ABORT_CMD, E_ABORT_TAIL, E_IDLE_JUNK} test_end_e;

    bit                                      clk;
    logic                                    reset;
    logic [rom_loader_pkg::BYTE_W-1:0]       uart_data;
    logic                                    uart_valid;
    logic                                    uart_ready;
    logic                                    rom_busy;
    logic                                    rom_done;
    logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] sdram_addr;
    logic [rom_loader_pkg::BYTE_W-1:0]       sdram_data;
    logic                                    sdram_wr;

    // Driver side strobes and the reference model registers
    logic                                    data_commit;
    logic                                    start_commit;
    logic                                    end_commit;
    logic                                    abort_commit;
    logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] exp_addr;
    logic [rom_loader_pkg::BYTE_W-1:0]       exp_data;
    logic                                    busy_model;
    logic                                    done_due;
    logic                                    wr_due;
    logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] addr_due;
    logic [rom_loader_pkg::BYTE_W-1:0]       data_due;

    logic [15:0] lfsr_state = 16'd13961;
    logic [32:0] exp_q[$];
    string       t_name[$];
    logic [2:0]  t_type[$];
    logic [23:0] t_off[$];
    logic [23:0] t_size[$];
    test_end_e   t_end[$];
    int          total_bytes = 0;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    int          error_count = 0;

    rom_loader i_dut (
        .clk        (clk),
        .reset      (reset),
        .uart_data  (uart_data),
        .uart_valid (uart_valid),
        .uart_ready (uart_ready),
        .rom_busy   (rom_busy),
        .rom_done   (rom_done),
        .sdram_addr (sdram_addr),
        .sdram_data (sdram_data),
        .sdram_wr   (sdram_wr)
    );

    initial begin : clock_gen
        forever begin
            #4;
            clk = ~clk;
        end
    end

    // 16-bit Galois LFSR
    function automatic logic next_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    function automatic logic [23:0] rand_bits(input int n);
        logic [23:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[22:0], next_bit()};
        end
        return r;
    endfunction

    // Expected SDRAM start address from the cartridge memory map
    function automatic logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] expected_start(
        input logic [2:0] rom_type, input logic [23:0] offset);
        logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] off;
        off = {1'b0, offset};
        case (rom_type)
            rom_loader_pkg::BIOS: return rom_loader_pkg::BASE_BIOS + off;
            rom_loader_pkg::P:    return rom_loader_pkg::BASE_P + off;
            rom_loader_pkg::S:    return rom_loader_pkg::BASE_S + off;
            rom_loader_pkg::M:    return rom_loader_pkg::BASE_M + off;
            rom_loader_pkg::V:    return rom_loader_pkg::BASE_V + off;
            rom_loader_pkg::C:    return rom_loader_pkg::BASE_C + off;
            rom_loader_pkg::NEO: begin
                if (offset >= rom_loader_pkg::NEO_S_START)
                    return rom_loader_pkg::BASE_S + off - {1'b0, rom_loader_pkg::NEO_S_START};
                if (offset >= rom_loader_pkg::NEO_M_START)
                    return rom_loader_pkg::BASE_M + off - {1'b0, rom_loader_pkg::NEO_M_START};
                if (offset >= rom_loader_pkg::NEO_V_START)
                    return rom_loader_pkg::BASE_V + off - {1'b0, rom_loader_pkg::NEO_V_START};
                if (offset >= rom_loader_pkg::NEO_C_START)
                    return rom_loader_pkg::BASE_C + off - {1'b0, rom_loader_pkg::NEO_C_START};
                return rom_loader_pkg::BASE_P + off;
            end
            default: return off;
        endcase
    endfunction

    task automatic clear_commits();
        data_commit  = 1'b0;
        start_commit = 1'b0;
        end_commit   = 1'b0;
        abort_commit = 1'b0;
    endtask

    task automatic add_test(input string name, input logic [2:0] ty, input logic [23:0] off,
                            input logic [23:0] size, input test_end_e how);
        t_name.push_back(name);
        t_type.push_back(ty);
        t_off.push_back(off);
        t_size.push_back(size);
        t_end.push_back(how);
        case (how)
            E_IDLE_JUNK: total_bytes += 4;
            E_ABORT_CMD: total_bytes += 10;
            default:     total_bytes += 11 + int'(size);
        endcase
    endtask

    // Returns on the falling edge before the edge that accepts the byte
    task automatic send_byte(input logic [7:0] value, input byte_kind_e kind,
                             input logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] addr);
        logic accepted;
        logic first;
        accepted = 1'b0;
        first    = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            clear_commits();
            // Valid may drop for one cycle ahead of each new byte
            if (first && next_bit()) begin
                uart_valid = 1'b0;
            end else begin
                uart_valid = 1'b1;
                uart_data  = value;
                accepted   = uart_ready;
            end
            first = 1'b0;
        end
        data_commit  = (kind == K_DATA);
        start_commit = (kind == K_START);
        end_commit   = (kind == K_END);
        abort_commit = (kind == K_ABORT);
        exp_addr     = addr;
        exp_data     = value;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            uart_valid = 1'b0;
            clear_commits();
        end
    endtask

    task automatic run_test(input int idx);
        logic [rom_loader_pkg::SDRAM_ADDR_W-1:0] start;
        logic [7:0]                              value;
        logic [32:0]                             pair;
        int                                      k;
        start = expected_start(t_type[idx], t_off[idx]);
        if (t_end[idx] == E_IDLE_JUNK) begin
            send_byte(8'h00, K_PLAIN, '0);
            send_byte(8'h05, K_PLAIN, '0);
            send_byte(8'h81, K_PLAIN, '0);
            send_byte(8'hFF, K_PLAIN, '0);
        end else begin
            send_byte(rom_loader_pkg::LOAD_START, K_START, '0);
            send_byte({5'd0, t_type[idx]}, K_PLAIN, '0);
            send_byte(t_off[idx][23:16], K_PLAIN, '0);
            send_byte(t_off[idx][15:8], K_PLAIN, '0);
            send_byte(t_off[idx][7:0], K_PLAIN, '0);
            send_byte(t_size[idx][23:16], K_PLAIN, '0);
            send_byte(t_size[idx][15:8], K_PLAIN, '0);
            send_byte(t_size[idx][7:0], K_PLAIN, '0);
            // Not a command, so S_CMD stays put
            send_byte(8'h5A, K_PLAIN, '0);
            if (t_end[idx] == E_ABORT_CMD) begin
                send_byte(rom_loader_pkg::LOAD_ABORT, K_ABORT, '0);
            end else begin
                send_byte(rom_loader_pkg::LOAD_DATA, K_PLAIN, '0);
                for (k = 0; k < int'(t_size[idx]); k++) begin
                    value = 8'(rand_bits(8));
                    // Command codes inside the data must be stored as data
                    if (k == 1) value = 8'h03;
                    if (k == 2) value = 8'h04;
                    exp_q.push_back({start + 25'(k), value});
                end
                while (exp_q.size() > 0) begin
                    pair = exp_q.pop_front();
                    send_byte(pair[7:0], K_DATA, pair[32:8]);
                end
                if (t_end[idx] == E_ABORT_TAIL) begin
                    send_byte(rom_loader_pkg::LOAD_ABORT, K_ABORT, '0);
                end else begin
                    send_byte(rom_loader_pkg::LOAD_END, K_END, '0);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            busy_model <= 1'b0;
            done_due   <= 1'b0;
            wr_due     <= 1'b0;
        end else begin
            wr_due   <= data_commit;
            addr_due <= exp_addr;
            data_due <= exp_data;
            done_due <= end_commit;
            if (start_commit) begin
                busy_model <= 1'b1;
            end else if (end_commit || abort_commit) begin
                busy_model <= 1'b0;
            end
        end
    end

    reset_quiet: assert property (@(negedge clk)
        reset |-> !uart_ready && !rom_busy && !rom_done && !sdram_wr)
        else begin
            error_count++;
            $display("Outputs are not all low during reset at %0t", $time);
        end

    ready_check: assert property (@(negedge clk) !reset |-> uart_ready == !done_due)
        else begin
            error_count++;
            $display("Error at %0t: uart_ready expected %b got %b", $time, !done_due, uart_ready);
        end

    busy_check: assert property (@(negedge clk) !reset |-> rom_busy == busy_model)
        else begin
            error_count++;
            $display("Error at %0t: rom_busy expected %b got %b", $time, busy_model, rom_busy);
        end

    done_check: assert property (@(negedge clk) !reset |-> rom_done == done_due)
        else begin
            error_count++;
            $display("Error at %0t: rom_done expected %b got %b", $time, done_due, rom_done);
        end

    wr_check: assert property (@(negedge clk) !reset |-> sdram_wr == wr_due)
        else begin
            error_count++;
            $display("Error at %0t: sdram_wr expected %b got %b", $time, wr_due, sdram_wr);
        end

    addr_check: assert property (@(negedge clk) wr_due |-> sdram_addr == addr_due)
        else begin
            error_count++;
            $display("Error at %0t: sdram_addr expected %h got %h", $time, addr_due, sdram_addr);
        end

    data_check: assert property (@(negedge clk) wr_due |-> sdram_data == data_due)
        else begin
            error_count++;
            $display("Error at %0t: sdram_data expected %h got %h", $time, data_due, sdram_data);
        end

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles before all tests finished", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int   errors_before;
        int   passed;
        int   failed;
        logic ok;
        reset      = 1'b1;
        uart_valid = 1'b0;
        uart_data  = '0;
        exp_addr   = '0;
        exp_data   = '0;
        clear_commits();
        passed = 0;
        failed = 0;
        add_test("idle bytes ignored", 3'd0, 24'd0, 24'd0, E_IDLE_JUNK);
        add_test("P load", rom_loader_pkg::P, rand_bits(20), 24'(3 + rand_bits(4)), E_END);
        add_test("C load", rom_loader_pkg::C, rand_bits(20), 24'(3 + rand_bits(4)), E_END);
        add_test("BIOS load", rom_loader_pkg::BIOS, rand_bits(16), 24'(3 + rand_bits(4)), E_END);
        add_test("NEO P region", rom_loader_pkg::NEO, rand_bits(16),
                 24'(3 + rand_bits(4)), E_END);
        add_test("NEO C region", rom_loader_pkg::NEO, rom_loader_pkg::NEO_C_START + rand_bits(16),
                 24'(3 + rand_bits(4)), E_END);
        add_test("NEO V region", rom_loader_pkg::NEO, rom_loader_pkg::NEO_V_START + rand_bits(16),
                 24'(3 + rand_bits(4)), E_END);
        add_test("NEO M region", rom_loader_pkg::NEO, rom_loader_pkg::NEO_M_START + rand_bits(16),
                 24'(3 + rand_bits(4)), E_END);
        add_test("NEO S region", rom_loader_pkg::NEO, rom_loader_pkg::NEO_S_START + rand_bits(16),
                 24'(3 + rand_bits(4)), E_END);
        add_test("type 7 load", 3'd7, rand_bits(20), 24'(3 + rand_bits(4)), E_END);
        add_test("size zero", rom_loader_pkg::V, rand_bits(16), 24'd0, E_END);
        add_test("abort in command state", rom_loader_pkg::S, rand_bits(16),
                 24'(3 + rand_bits(4)), E_ABORT_CMD);
        add_test("abort after data", rom_loader_pkg::M, rand_bits(16),
                 24'(3 + rand_bits(4)), E_ABORT_TAIL);
        cycle_limit = 2 * total_bytes + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (t_name[i]) begin
            errors_before = error_count;
            run_test(i);
            idle_cycles(3);
            ok = (error_count == errors_before);
            if (ok) begin
                passed++;
            end else begin
                failed++;
            end
            $display("%s: %s", t_name[i], ok ? "pass" : "fail");
        end
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rom_loader.f
source/rom_loader_pkg.sv
source/loader_ctrl_if.sv
source/load_sequencer.sv
source/header_capture.sv
source/region_mapper.sv
source/sdram_write_stream.sv
source/rom_loader.sv
dv/tb_rom_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run, status follows the pass line of the testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_rom_loader -Mdir obj_dir \
    -f rom_loader.f || exit 1
./obj_dir/Vtb_rom_loader | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
    && exit 0 || exit 1
